// File: project.f
rtl/video_sync_pkg.sv
rtl/frame_sync_buffer.sv
rtl/pulse_width_checker.sv
rtl/blanking_checker.sv
rtl/stream_monitor.sv
rtl/video_sync_top.sv
verif/video_sync_properties.sv
verif/tb_video_sync.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_sync
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_video_sync.sv
`timescale 1ns/10ps
`default_nettype none

module tb_video_sync;
	import video_sync_pkg::*;

	// one sample of the gated stream
	typedef struct packed {
		logic     fval;
		logic     lval;
		pix_bus_t pix;
	} stream_sample_t;

	localparam pulse_cnt_t MIN_FVAL_HIGH = 16'd20;
	localparam pulse_cnt_t MIN_FVAL_LOW  = 16'd20;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 5;
	localparam int DRAIN_CYCLES = 6;
	localparam int LINE_LEN     = 8;
	localparam int HBLANK       = 4;
	localparam int FRAME_NUM    = 12;

	// --------------------
	// frame table
	// --------------------
	// lines per frame
	// frame 9 is only 12 cycles high
	localparam int FRAME_H [FRAME_NUM] = '{4, 4, 4, 4, 4, 4, 4, 4, 4, 1, 4, 4};
	// vertical blank after the frame
	// frame 10 is too short
	localparam int FRAME_VB [FRAME_NUM] = '{24, 24, 24, 24, 24, 24, 24, 24, 24, 24, 12, 24};
	// sample index where enable changes
	// -1 leaves enable as it is
	localparam int EN_INDEX [FRAME_NUM] = '{-1, -1, -1, 10, -1, -1, 20, -1, 0, -1, -1, -1};
	localparam bit EN_VALUE [FRAME_NUM] = '{0, 0, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0};
	// nonzero data in the first horizontal blank
	localparam bit INJECT [FRAME_NUM] = '{0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1};

	logic     clk_in;
	logic     i_arst_n;
	logic     i_enable;
	logic     i_fval;
	logic     i_lval;
	pix_bus_t i_pix_data;
	logic     o_fval;
	logic     o_lval;
	pix_bus_t o_pix_data;
	logic     o_fval_high_err;
	logic     o_fval_low_err;
	logic     o_blank_err;

	int seed;
	int cycle_count = 0;
	int timeout_limit;

	// reference model state
	stream_sample_t sample_q[$];
	logic       gate_fwd       = 1'b0;
	logic       gate_prev_fval = 1'b0;
	logic       mon_prev_fval  = 1'b0;
	logic       low_seen       = 1'b0;
	pulse_cnt_t high_len       = '0;
	pulse_cnt_t low_len        = '0;
	logic       exp_high_err   = 1'b0;
	logic       exp_low_err    = 1'b0;
	logic       exp_blank_err  = 1'b0;

	video_sync_top #(
		.MIN_FVAL_HIGH (MIN_FVAL_HIGH),
		.MIN_FVAL_LOW  (MIN_FVAL_LOW)
	) UUT (
		.clk_in          (clk_in),
		.i_arst_n        (i_arst_n),
		.i_enable        (i_enable),
		.i_fval          (i_fval),
		.i_lval          (i_lval),
		.i_pix_data      (i_pix_data),
		.o_fval          (o_fval),
		.o_lval          (o_lval),
		.o_pix_data      (o_pix_data),
		.o_fval_high_err (o_fval_high_err),
		.o_fval_low_err  (o_fval_low_err),
		.o_blank_err     (o_blank_err)
	);

	initial begin
		clk_in = 1'b0;
		forever #50 clk_in = ~clk_in;
	end

	// --------------------
	// reference model
	// --------------------
	// gate opens at a frame start with enable high and closes in blanking with enable low
	function automatic stream_sample_t expected_stream(input logic fval, input logic lval,
			input pix_bus_t pix, input logic en);
		stream_sample_t gated;
		stream_sample_t result;
		if (fval && !gate_prev_fval) begin
			gate_fwd = gate_fwd | en;
		end else if (!fval && !en) begin
			gate_fwd = 1'b0;
		end
		gate_prev_fval = fval;
		gated.fval = gate_fwd & fval;
		gated.lval = gate_fwd & lval;
		gated.pix  = gate_fwd ? pix : '0;
		sample_q.push_back(gated);
		// output lags the input by two samples
		result = '0;
		if (sample_q.size() > 2) begin
			result = sample_q.pop_front();
		end
		return result;
	endfunction

	// width and blanking rules on the expected stream
	// flags show one cycle later
	function automatic void update_flag_model(input stream_sample_t s);
		if (s.fval && !mon_prev_fval) begin
			// end of a low pulse is judged only once its start was seen
			if (low_seen && low_len < MIN_FVAL_LOW) begin
				exp_low_err = 1'b1;
			end
			high_len = pulse_cnt_t'(1);
		end else if (s.fval) begin
			high_len = high_len + pulse_cnt_t'(1);
		end else if (mon_prev_fval) begin
			if (high_len < MIN_FVAL_HIGH) begin
				exp_high_err = 1'b1;
			end
			low_seen = 1'b1;
			low_len  = pulse_cnt_t'(1);
		end else begin
			low_len = low_len + pulse_cnt_t'(1);
		end
		if (!s.lval && s.pix != '0) begin
			exp_blank_err = 1'b1;
		end
		mon_prev_fval = s.fval;
	endfunction

	function automatic int frame_cycles(input int idx);
		return FRAME_H[idx] * (LINE_LEN + HBLANK) + FRAME_VB[idx];
	endfunction

	// --------------------
	// checks
	// --------------------
	task automatic stop_with_failure();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic check_pix(input string name, input pix_bus_t expected, input pix_bus_t actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic expect_flags(input logic high_err, input logic low_err, input logic blank_err);
		@(negedge clk_in);
		check_flag("o_fval_high_err", high_err, o_fval_high_err);
		check_flag("o_fval_low_err", low_err, o_fval_low_err);
		check_flag("o_blank_err", blank_err, o_blank_err);
	endtask

	// compare every cycle on the falling edge where the outputs are stable
	always @(negedge clk_in) begin
		stream_sample_t exp_s;
		if (i_arst_n) begin
			exp_s = expected_stream(i_fval, i_lval, i_pix_data, i_enable);
			check_level("o_fval", exp_s.fval, o_fval);
			check_level("o_lval", exp_s.lval, o_lval);
			check_pix("o_pix_data", exp_s.pix, o_pix_data);
			check_flag("o_fval_high_err", exp_high_err, o_fval_high_err);
			check_flag("o_fval_low_err", exp_low_err, o_fval_low_err);
			check_flag("o_blank_err", exp_blank_err, o_blank_err);
			update_flag_model(exp_s);
			if (UUT.u_props.fail_count != 0) begin
				$display("a bound assertion on the top-level ports failed");
				stop_with_failure();
			end
		end
	end

	always @(posedge clk_in) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("timeout, the stimulus did not finish within %0d cycles", timeout_limit);
			stop_with_failure();
		end
	end

	// --------------------
	// stimulus
	// --------------------
	task automatic drive_sample(input logic en, input logic fval, input logic lval,
			input pix_bus_t pix);
		@(posedge clk_in);
		#1;
		i_enable   = en;
		i_fval     = fval;
		i_lval     = lval;
		i_pix_data = pix;
	endtask

	// lines of active pixels and horizontal blank followed by the vertical blank
	task automatic send_frame(input int idx);
		int       n;
		int       line;
		int       col;
		logic     en;
		pix_bus_t pix;
		n  = 0;
		en = i_enable;
		for (line = 0; line < FRAME_H[idx]; line++) begin
			for (col = 0; col < LINE_LEN + HBLANK; col++) begin
				if (n == EN_INDEX[idx]) begin
					en = EN_VALUE[idx];
				end
				if (col < LINE_LEN) begin
					pix = pix_bus_t'($random(seed));
				end else if (INJECT[idx] && line == 0 && col == LINE_LEN + 1) begin
					pix = pix_bus_t'(20'h3a5);
				end else begin
					pix = '0;
				end
				drive_sample(en, 1'b1, col < LINE_LEN, pix);
				n = n + 1;
			end
		end
		repeat (FRAME_VB[idx]) begin
			drive_sample(en, 1'b0, 1'b0, '0);
		end
	endtask

	initial begin
		// live stream during reset must not reach the outputs
		i_arst_n   = 1'b0;
		i_enable   = 1'b1;
		i_fval     = 1'b1;
		i_lval     = 1'b1;
		i_pix_data = '1;
		seed       = 32'ha1096691;
		timeout_limit = RESET_CYCLES + IDLE_CYCLES + DRAIN_CYCLES + 200;
		for (int i = 0; i < FRAME_NUM; i++) begin
			timeout_limit = timeout_limit + frame_cycles(i);
		end
		repeat (RESET_CYCLES) @(posedge clk_in);
		#1;
		i_arst_n   = 1'b1;
		i_enable   = 1'b0;
		i_fval     = 1'b0;
		i_lval     = 1'b0;
		i_pix_data = '0;
		repeat (IDLE_CYCLES) begin
			drive_sample(1'b0, 1'b0, 1'b0, '0);
		end
		for (int i = 0; i < FRAME_NUM; i++) begin
			send_frame(i);
			// gate still closed so the injection must stay invisible
			if (i == 2) begin
				expect_flags(1'b0, 1'b0, 1'b0);
			end
			// only legal widths up to here
			if (i == 8) begin
				expect_flags(1'b0, 1'b0, 1'b0);
			end
		end
		repeat (DRAIN_CYCLES) begin
			drive_sample(1'b0, 1'b0, 1'b0, '0);
		end
		expect_flags(1'b1, 1'b1, 1'b1);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/video_sync_properties.sv
`timescale 1ns/10ps
`default_nettype none

module video_sync_properties (
	input wire                           clk_in,
	input wire                           i_arst_n,
	input wire                           o_fval,
	input wire                           o_lval,
	input wire video_sync_pkg::pix_bus_t o_pix_data,
	input wire                           o_fval_high_err,
	input wire                           o_fval_low_err,
	input wire                           o_blank_err
);

	// failed assertions so far, polled by the testbench
	int unsigned fail_count = 0;

	// --------------------
	// reset values
	// --------------------
	reset_outputs_zero: assert property (@(posedge clk_in)
		!i_arst_n |-> (!o_fval && !o_lval && (o_pix_data == '0)
			&& !o_fval_high_err && !o_fval_low_err && !o_blank_err))
	else begin
		fail_count++;
		$error("outputs not zero during reset");
	end

	// --------------------
	// stream shape
	// --------------------
	lval_inside_fval: assert property (@(posedge clk_in) disable iff (!i_arst_n)
		o_lval |-> o_fval)
	else begin
		fail_count++;
		$error("o_lval high while o_fval low");
	end

	// --------------------
	// sticky flags
	// --------------------
	high_err_sticky: assert property (@(posedge clk_in) disable iff (!i_arst_n)
		o_fval_high_err |=> o_fval_high_err)
	else begin
		fail_count++;
		$error("o_fval_high_err dropped");
	end

	low_err_sticky: assert property (@(posedge clk_in) disable iff (!i_arst_n)
		o_fval_low_err |=> o_fval_low_err)
	else begin
		fail_count++;
		$error("o_fval_low_err dropped");
	end

	blank_err_sticky: assert property (@(posedge clk_in) disable iff (!i_arst_n)
		o_blank_err |=> o_blank_err)
	else begin
		fail_count++;
		$error("o_blank_err dropped");
	end

endmodule

bind video_sync_top video_sync_properties u_props (.*);

`default_nettype wire

// File: rtl/video_sync_top.sv
`timescale 1ns/10ps
`default_nettype none

module video_sync_top #(
	parameter video_sync_pkg::pulse_cnt_t MIN_FVAL_HIGH = 16'd20,
	parameter video_sync_pkg::pulse_cnt_t MIN_FVAL_LOW  = 16'd20
) (
	input  wire                           clk_in,
	input  wire                           i_arst_n,
	input  wire                           i_enable,
	input  wire                           i_fval,
	input  wire                           i_lval,
	input  wire video_sync_pkg::pix_bus_t i_pix_data,
	output logic                          o_fval,
	output logic                          o_lval,
	output video_sync_pkg::pix_bus_t      o_pix_data,
	output logic                          o_fval_high_err,
	output logic                          o_fval_low_err,
	output logic                          o_blank_err
);
	import video_sync_pkg::*;

	// gated stream, 2 cycles behind the input
	logic     stream_fval;
	logic     stream_lval;
	pix_bus_t stream_pix;

	// --------------------
	// whole frame gate
	// --------------------
	frame_sync_buffer u_buffer (
		.clk_in     (clk_in),
		.i_arst_n   (i_arst_n),
		.i_enable   (i_enable),
		.i_fval     (i_fval),
		.i_lval     (i_lval),
		.i_pix_data (i_pix_data),
		.o_fval     (stream_fval),
		.o_lval     (stream_lval),
		.o_pix_data (stream_pix)
	);

	assign o_fval     = stream_fval;
	assign o_lval     = stream_lval;
	assign o_pix_data = stream_pix;

	// --------------------
	// monitor on the output
	// --------------------
	stream_monitor #(
		.MIN_FVAL_HIGH (MIN_FVAL_HIGH),
		.MIN_FVAL_LOW  (MIN_FVAL_LOW)
	) u_monitor (
		.clk_in          (clk_in),
		.i_arst_n        (i_arst_n),
		.i_fval          (stream_fval),
		.i_lval          (stream_lval),
		.i_pix_data      (stream_pix),
		.o_fval_high_err (o_fval_high_err),
		.o_fval_low_err  (o_fval_low_err),
		.o_blank_err     (o_blank_err)
	);

endmodule

`default_nettype wire

// File: rtl/stream_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module stream_monitor #(
	parameter video_sync_pkg::pulse_cnt_t MIN_FVAL_HIGH = 16'd20,
	parameter video_sync_pkg::pulse_cnt_t MIN_FVAL_LOW  = 16'd20
) (
	input  wire                           clk_in,
	input  wire                           i_arst_n,
	input  wire                           i_fval,
	input  wire                           i_lval,
	input  wire video_sync_pkg::pix_bus_t i_pix_data,
	output logic                          o_fval_high_err,
	output logic                          o_fval_low_err,
	output logic                          o_blank_err
);

	// --------------------
	// frame valid widths
	// --------------------

	// active frame too short
	pulse_width_checker #(
		.PULSE_POL (1'b1),
		.MIN_WIDTH (MIN_FVAL_HIGH)
	) u_fval_high_chk (
		.clk_in   (clk_in),
		.i_arst_n (i_arst_n),
		.i_din    (i_fval),
		.o_error  (o_fval_high_err)
	);

	// vertical blanking too short
	pulse_width_checker #(
		.PULSE_POL (1'b0),
		.MIN_WIDTH (MIN_FVAL_LOW)
	) u_fval_low_chk (
		.clk_in   (clk_in),
		.i_arst_n (i_arst_n),
		.i_din    (i_fval),
		.o_error  (o_fval_low_err)
	);

	// --------------------
	// blanking data
	// --------------------
	blanking_checker u_blank_chk (
		.clk_in     (clk_in),
		.i_arst_n   (i_arst_n),
		.i_lval     (i_lval),
		.i_pix_data (i_pix_data),
		.o_error    (o_blank_err)
	);

endmodule

`default_nettype wire

// File: rtl/blanking_checker.sv
`timescale 1ns/10ps
`default_nettype none

module blanking_checker (
	input  wire                           clk_in,
	input  wire                           i_arst_n,
	input  wire                           i_lval,
	input  wire video_sync_pkg::pix_bus_t i_pix_data,
	output logic                          o_error
);

	// any pixel bit set on this sample
	logic data_nonzero;
	// data seen outside a line
	logic blank_hit;

	// --------------------
	// detect
	// --------------------

	// reduction over both channels
	assign data_nonzero = |i_pix_data;

	// lval low covers both horizontal and vertical blanking,
	// so fval is not needed here
	assign blank_hit = !i_lval && data_nonzero;

	// --------------------
	// sticky flag
	// --------------------
	always_ff @(posedge clk_in or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_error <= 1'b0;
		end else if (blank_hit) begin
			// held until the next reset
			o_error <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pulse_width_checker.sv
`timescale 1ns/10ps
`default_nettype none

module pulse_width_checker #(
	// 1 checks high pulses, 0 checks low pulses
	parameter bit                         PULSE_POL = 1'b1,
	parameter video_sync_pkg::pulse_cnt_t MIN_WIDTH = 16'd20
) (
	input  wire  clk_in,
	input  wire  i_arst_n,
	input  wire  i_din,
	output logic o_error
);
	import video_sync_pkg::*;

	// level of the previous sample
	logic       din_q;
	logic       in_pulse;
	logic       pulse_start;
	logic       pulse_end;
	// a start edge was seen since reset
	logic       seen_edge;
	// cycles spent in the watched level so far
	pulse_cnt_t pulse_cnt;

	// --------------------
	// edge detect
	// --------------------
	assign in_pulse    = (i_din == PULSE_POL);
	assign pulse_start = in_pulse && (din_q != PULSE_POL);
	assign pulse_end   = !in_pulse && (din_q == PULSE_POL);

	// --------------------
	// length counter
	// --------------------
	always_ff @(posedge clk_in or negedge i_arst_n) begin
		if (!i_arst_n) begin
			din_q     <= 1'b0;
			seen_edge <= 1'b0;
			pulse_cnt <= '0;
		end else begin
			din_q <= i_din;
			if (pulse_start) begin
				seen_edge <= 1'b1;
				pulse_cnt <= pulse_cnt_t'(1);
			end else if (in_pulse) begin
				// saturate on very long pulses
				if (pulse_cnt != '1) begin
					pulse_cnt <= pulse_cnt + pulse_cnt_t'(1);
				end
			end else begin
				pulse_cnt <= '0;
			end
		end
	end

	// sticky flag, pulse already running at reset is not judged
	always_ff @(posedge clk_in or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_error <= 1'b0;
		end else if (pulse_end && seen_edge && (pulse_cnt < MIN_WIDTH)) begin
			o_error <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/frame_sync_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sync_buffer (
	input  wire                           clk_in,
	input  wire                           i_arst_n,
	input  wire                           i_enable,
	input  wire                           i_fval,
	input  wire                           i_lval,
	input  wire video_sync_pkg::pix_bus_t i_pix_data,
	output logic                          o_fval,
	output logic                          o_lval,
	output video_sync_pkg::pix_bus_t      o_pix_data
);
	import video_sync_pkg::*;

	// stage 1 of the stream, enable delayed to match
	logic        fval_d1;
	logic        lval_d1;
	logic        enable_d1;
	pix_bus_t    pix_d1;
	// ungated copy of the previous stage 1 fval
	logic        fval_d2;
	logic        fval_rise;
	// current sample goes through the gate
	logic        pass;
	gate_state_t gate_state;
	gate_state_t gate_next;

	// --------------------
	// stage 1 registers
	// --------------------
	always_ff @(posedge clk_in or negedge i_arst_n) begin
		if (!i_arst_n) begin
			fval_d1   <= 1'b0;
			lval_d1   <= 1'b0;
			enable_d1 <= 1'b0;
			fval_d2   <= 1'b0;
		end else begin
			fval_d1   <= i_fval;
			lval_d1   <= i_lval;
			enable_d1 <= i_enable;
			fval_d2   <= fval_d1;
		end
	end

	// pixel payload
	always_ff @(posedge clk_in) begin
		pix_d1 <= i_pix_data;
	end

	// frame start on the delayed stream
	assign fval_rise = fval_d1 & ~fval_d2;

	// --------------------
	// gate fsm
	// --------------------
	always_comb begin
		gate_next = gate_state;
		case (gate_state)
			gate_closed: begin
				// open only on a frame start, else wait out the running frame
				if (enable_d1 && fval_rise) begin
					gate_next = gate_open;
				end else if (enable_d1 && fval_d1) begin
					gate_next = gate_wait_blank;
				end
			end
			gate_wait_blank: begin
				if (!enable_d1) begin
					gate_next = gate_closed;
				end else if (fval_rise) begin
					gate_next = gate_open;
				end
			end
			gate_open: begin
				// close only once the frame is over
				if (!enable_d1 && !fval_d1) begin
					gate_next = gate_closed;
				end
			end
			default: gate_next = gate_closed;
		endcase
	end

	assign pass = (gate_next == gate_open);

	// --------------------
	// stage 2, gated output
	// --------------------
	always_ff @(posedge clk_in or negedge i_arst_n) begin
		if (!i_arst_n) begin
			gate_state <= gate_closed;
			o_fval     <= 1'b0;
			o_lval     <= 1'b0;
			o_pix_data <= '0;
		end else begin
			gate_state <= gate_next;
			o_fval     <= pass & fval_d1;
			o_lval     <= pass & lval_d1;
			o_pix_data <= pass ? pix_d1 : '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/video_sync_pkg.sv
`default_nettype none

package video_sync_pkg;

	// --------------------
	// pixel geometry
	// --------------------

	// bits per pixel channel
	localparam int DATA_WIDTH  = 10;
	// channels packed in one pixel word
	localparam int CHANNEL_NUM = 2;

	// packed pixel word, channel 0 in the low bits
	typedef logic [DATA_WIDTH*CHANNEL_NUM-1:0] pix_bus_t;

	// --------------------
	// pulse measurement
	// --------------------

	// pulse length counter width
	localparam int COUNT_WIDTH = 16;

	// pulse length and minimum width value
	typedef logic [COUNT_WIDTH-1:0] pulse_cnt_t;

	// gate of the frame sync buffer
	typedef enum logic [1:0] {
		gate_closed     = 2'd0,
		// enabled mid-frame, wait for the next frame start
		gate_wait_blank = 2'd1,
		gate_open       = 2'd2
	} gate_state_t;

endpackage

`default_nettype wire
